//--- axi_to_mem.f
verilog/axi_burst_pkg.sv
verilog/mem_port_pkg.sv
verilog/resp_fifo.sv
verilog/burst_sequencer.sv
verilog/rw_arbiter.sv
verilog/mem_stream_port.sv
verilog/resp_composer.sv
verilog/axi_to_mem.sv
testbench/tb_axi_to_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the axi_to_mem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_to_mem -f axi_to_mem.f -o sim_tb_axi_to_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_axi_to_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
  exit 0
fi
exit 1

//--- testbench/tb_axi_to_mem.sv
// Testbench for the AXI4 to memory bridge.
// Drives bursts through AXI, models the memory and checks R, B and the memory port.
`timescale 1ns/1ps

module tb_axi_to_mem;

  localparam int unsigned BufDepth  = 2;
  localparam int unsigned TestBeats = 160;
  // Every beat gets a generous number of cycles under random back-pressure.
  localparam int unsigned MaxCycles = TestBeats * 40 + 500;

  logic clk_i = 1'b0;
  logic rst_i;
  axi_burst_pkg::axi_req_t  axi_req;
  axi_burst_pkg::axi_resp_t axi_resp;
  mem_port_pkg::mem_req_t   mem_req_o;
  logic                     mem_valid_o, mem_gnt_i, mem_rvalid_i;
  mem_port_pkg::mem_rsp_t   mem_rsp_i;

  axi_burst_pkg::ax_chan_t aw, ar;
  axi_burst_pkg::w_chan_t  w;
  logic aw_valid, w_valid, ar_valid, b_ready, r_ready;

  logic [7:0]  mem [65536];
  logic [7:0]  shadow [65536];
  logic [31:0] hs_state, data_state;
  int unsigned cycles, value_errs, proto_errs;
  logic        pend, watch_first, r_stall_q, b_stall_q, m_stall_q;
  axi_burst_pkg::addr_t    wa;
  mem_port_pkg::mem_rsp_t  pend_rsp;
  mem_port_pkg::mem_req_t  m_q;
  axi_burst_pkg::r_chan_t  r_q, exp_r;
  axi_burst_pkg::b_chan_t  b_q, exp_b;
  axi_burst_pkg::r_chan_t  exp_r_q [$];
  axi_burst_pkg::b_chan_t  exp_b_q [$];

  assign axi_req = '{aw: aw, aw_valid: aw_valid, w: w, w_valid: w_valid, b_ready: b_ready,
                     ar: ar, ar_valid: ar_valid, r_ready: r_ready};

  axi_to_mem #(.BufDepth(BufDepth)) axi_to_mem_i (
    .clk_i, .rst_i, .axi_req_i(axi_req), .axi_resp_o(axi_resp),
    .mem_req_o, .mem_valid_o, .mem_gnt_i, .mem_rsp_i, .mem_rvalid_i
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Background byte for an address that was never written.
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  function automatic axi_burst_pkg::resp_t beat_resp(input logic err, input logic lock);
    if (err) begin
      return axi_burst_pkg::RespSlverr;
    end
    return lock ? axi_burst_pkg::RespExokay : axi_burst_pkg::RespOkay;
  endfunction

  function automatic void check_value(input string name, input logic [63:0] got,
                                      input logic [63:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endfunction

  task automatic check_idle_outputs();
    assert (!axi_resp.aw_ready && !axi_resp.w_ready && !axi_resp.ar_ready &&
            !axi_resp.r_valid && !axi_resp.b_valid && !mem_valid_o) else begin
      proto_errs++;
      $display("A ready or valid output is high around reset");
    end
  endtask

  // Handshake randomization and the memory response change on the falling edge.
  always @(negedge clk_i) begin
    if (!rst_i) begin
      hs_state  = xorshift(hs_state);
      mem_gnt_i = hs_state[0] | hs_state[1];
      r_ready   = hs_state[4] | hs_state[5];
      b_ready   = hs_state[8] | hs_state[9];
    end
    mem_rvalid_i = pend;
    mem_rsp_i    = pend_rsp;
  end

  // Memory model answers each grant one cycle later.
  always @(posedge clk_i) begin
    if (rst_i) begin
      pend <= 1'b0;
    end else begin
      pend <= mem_valid_o & mem_gnt_i;
      if (mem_valid_o && mem_gnt_i) begin
        wa = {mem_req_o.addr[15:2], 2'b00};
        pend_rsp <= '{rdata: {mem[wa + 3], mem[wa + 2], mem[wa + 1], mem[wa]},
                      err: mem_req_o.addr[12],
                      exokay: mem_req_o.lock & ~mem_req_o.addr[12]};
        if (mem_req_o.we) begin
          for (int k = 0; k < 4; k++) begin
            if (mem_req_o.strb[k]) begin
              mem[wa + k] = mem_req_o.wdata[8*k +: 8];
            end
          end
        end
      end
    end
  end

  // Response monitors and stability checks.
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (axi_resp.r_valid && r_ready) begin
        if (exp_r_q.size() == 0) begin
          proto_errs++;
          $display("R beat arrived with none expected");
        end else begin
          exp_r = exp_r_q.pop_front();
          check_value("r.id", axi_resp.r.id, exp_r.id);
          check_value("r.data", axi_resp.r.data, exp_r.data);
          check_value("r.resp", axi_resp.r.resp, exp_r.resp);
          check_value("r.last", axi_resp.r.last, exp_r.last);
        end
      end
      if (axi_resp.b_valid && b_ready) begin
        if (exp_b_q.size() == 0) begin
          proto_errs++;
          $display("B response arrived with none expected");
        end else begin
          exp_b = exp_b_q.pop_front();
          check_value("b.id", axi_resp.b.id, exp_b.id);
          check_value("b.resp", axi_resp.b.resp, exp_b.resp);
        end
      end
      if (r_stall_q) begin
        check_value("r_valid", axi_resp.r_valid, 1'b1);
        check_value("r", axi_resp.r, r_q);
      end
      if (b_stall_q) begin
        check_value("b_valid", axi_resp.b_valid, 1'b1);
        check_value("b", axi_resp.b, b_q);
      end
      if (m_stall_q) begin
        check_value("mem_valid_o", mem_valid_o, 1'b1);
        check_value("mem_req_o", mem_req_o, m_q);
      end
      if (watch_first && mem_valid_o && mem_gnt_i) begin
        check_value("mem_req_o.we", mem_req_o.we, 1'b0);
        watch_first <= 1'b0;
      end
    end
    r_stall_q <= ~rst_i & axi_resp.r_valid & ~r_ready;
    b_stall_q <= ~rst_i & axi_resp.b_valid & ~b_ready;
    m_stall_q <= ~rst_i & mem_valid_o & ~mem_gnt_i;
    r_q       <= axi_resp.r;
    b_q       <= axi_resp.b;
    m_q       <= mem_req_o;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles with bursts still open", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                             input logic [7:0] len, input logic lock, input logic [3:0] qos);
    logic [15:0]            a;
    logic                   err;
    int                     beat;
    axi_burst_pkg::b_chan_t b_exp;
    err      = 1'b0;
    aw       = '{id: id, addr: addr, len: len, size: 3'd2, burst: axi_burst_pkg::BurstIncr,
                 lock: lock, qos: qos};
    aw_valid = 1'b1;
    for (beat = 0; beat <= len; beat++) begin
      a          = addr + 16'(4 * beat);
      data_state = xorshift(data_state);
      w          = '{data: data_state, strb: data_state[3:0] ^ data_state[11:8],
                     last: (beat == len)};
      w_valid    = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!axi_resp.w_ready);
      for (int k = 0; k < 4; k++) begin
        if (w.strb[k]) begin
          shadow[{a[15:2], 2'b00} + k] = w.data[8*k +: 8];
        end
      end
      err = err | a[12];
      if (beat == len) begin
        b_exp = '{id: id, resp: beat_resp(err, lock)};
        exp_b_q.push_back(b_exp);
      end
      @(negedge clk_i);
      aw_valid = 1'b0;
    end
    w_valid = 1'b0;
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
                            input logic [7:0] len, input logic lock, input logic [3:0] qos);
    logic [15:0]            a;
    axi_burst_pkg::r_chan_t r_exp;
    for (int beat = 0; beat <= len; beat++) begin
      a     = {addr[15:2], 2'b00} + 16'(4 * beat);
      r_exp = '{id: id, data: {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]},
                resp: beat_resp(a[12], lock), last: (beat == len)};
      exp_r_q.push_back(r_exp);
    end
    ar       = '{id: id, addr: addr, len: len, size: 3'd2, burst: axi_burst_pkg::BurstIncr,
                 lock: lock, qos: qos};
    ar_valid = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!axi_resp.ar_ready);
    @(negedge clk_i);
    ar_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_r_q.size() != 0 || exp_b_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  initial begin
    logic [15:0] addr;
    logic [7:0]  len;
    rst_i = 1'b1;
    {aw, ar, w} = '0;
    {aw_valid, w_valid, ar_valid, b_ready, r_ready} = '0;
    {mem_gnt_i, mem_rvalid_i, pend, watch_first} = '0;
    mem_rsp_i  = '0;
    pend_rsp   = '0;
    hs_state   = 32'd99606;
    data_state = 32'd99606 ^ 32'h5555_aaaa;
    {cycles, value_errs, proto_errs} = '0;
    for (int a = 0; a < 65536; a++) begin
      mem[a]    = fill_byte(a);
      shadow[a] = fill_byte(a);
    end
    repeat (3) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    rst_i = 1'b0;
    @(posedge clk_i);
    check_idle_outputs();
    @(negedge clk_i);

    write_burst(4'd3, 16'h0100, 8'd7, 1'b0, 4'd0);
    read_burst(4'd5, 16'h0100, 8'd7, 1'b0, 4'd0);
    wait_idle();
    write_burst(4'd6, 16'h0200, 8'd3, 1'b1, 4'd2);
    read_burst(4'd7, 16'h0200, 8'd3, 1'b1, 4'd2);
    wait_idle();
    // Crosses into the region that answers with an error.
    write_burst(4'd9, 16'h0ff8, 8'd3, 1'b0, 4'd0);
    read_burst(4'd10, 16'h0ff8, 8'd3, 1'b1, 4'd0);
    write_burst(4'd11, 16'h0040, 8'd0, 1'b0, 4'd0);
    wait_idle();
    for (int i = 0; i < 6; i++) begin
      data_state = xorshift(data_state);
      addr = {3'b000, data_state[12:4], 4'h0};
      len  = {5'd0, data_state[18:16]};
      write_burst(data_state[23:20], addr, len, data_state[24], data_state[28:25]);
      read_burst(data_state[23:20] ^ 4'hf, addr, len, data_state[24], 4'd0);
    end
    wait_idle();

    // Read with high QoS against a single-beat write with low QoS.
    watch_first = 1'b1;
    fork
      read_burst(4'd1, 16'h0300, 8'd1, 1'b0, 4'd8);
      write_burst(4'd2, 16'h0400, 8'd0, 1'b0, 4'd1);
    join
    wait_idle();

    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verilog/axi_to_mem.sv
// AXI4 to memory bridge.
// Turns INCR bursts into one in-order memory request stream.
`timescale 1ns/1ps

module axi_to_mem #(
  parameter int unsigned BufDepth = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  axi_burst_pkg::axi_req_t axi_req_i,
  output axi_burst_pkg::axi_resp_t axi_resp_o,
  output mem_port_pkg::mem_req_t  mem_req_o,
  output logic                    mem_valid_o,
  input  logic                    mem_gnt_i,
  input  mem_port_pkg::mem_rsp_t  mem_rsp_i,
  input  logic                    mem_rvalid_i
);

  mem_port_pkg::beat_meta_t rd_beat, wr_beat, meta, meta_buf;
  mem_port_pkg::route_t     route, route_buf;
  mem_port_pkg::mem_req_t   m2s_req;
  mem_port_pkg::mem_rsp_t   m2s_rsp;
  axi_burst_pkg::data_t     wdata;
  logic rd_valid, rd_ready, wr_valid, wr_ready, rd_busy, wr_busy;
  logic m2s_req_valid, m2s_req_ready, m2s_rsp_valid, m2s_rsp_ready;
  logic meta_valid, meta_ready, meta_buf_valid, meta_buf_ready;
  logic route_valid, route_ready, route_buf_valid, route_buf_ready;

  burst_sequencer burst_sequencer_i (
    .clk_i, .rst_i, .axi_req_i,
    .ar_ready_o(axi_resp_o.ar_ready), .aw_ready_o(axi_resp_o.aw_ready),
    .w_ready_o (axi_resp_o.w_ready),
    .rd_beat_o (rd_beat), .rd_valid_o(rd_valid), .rd_ready_i(rd_ready),
    .wr_beat_o (wr_beat), .wr_valid_o(wr_valid), .wr_ready_i(wr_ready),
    .rd_busy_o (rd_busy), .wr_busy_o (wr_busy), .wdata_o   (wdata)
  );

  rw_arbiter rw_arbiter_i (
    .clk_i, .rst_i,
    .rd_beat_i (rd_beat), .wr_beat_i (wr_beat),
    .rd_valid_i(rd_valid), .wr_valid_i(wr_valid),
    .rd_ready_o(rd_ready), .wr_ready_o(wr_ready),
    .rd_busy_i (rd_busy), .wr_busy_i (wr_busy), .wdata_i(wdata),
    .mem_req_o (m2s_req), .mem_req_valid_o(m2s_req_valid), .mem_req_ready_i(m2s_req_ready),
    .meta_o    (meta), .meta_valid_o(meta_valid), .meta_ready_i(meta_ready),
    .route_o   (route), .route_valid_o(route_valid), .route_ready_i(route_ready)
  );

  resp_fifo #(.Depth(BufDepth + 1), .payload_t(mem_port_pkg::beat_meta_t)) meta_fifo_i (
    .clk_i, .rst_i,
    .data_i (meta), .valid_i(meta_valid), .ready_o(meta_ready),
    .data_o (meta_buf), .valid_o(meta_buf_valid), .ready_i(meta_buf_ready)
  );

  resp_fifo #(.Depth(BufDepth + 1), .payload_t(mem_port_pkg::route_t)) route_fifo_i (
    .clk_i, .rst_i,
    .data_i (route), .valid_i(route_valid), .ready_o(route_ready),
    .data_o (route_buf), .valid_o(route_buf_valid), .ready_i(route_buf_ready)
  );

  mem_stream_port #(.BufDepth(BufDepth)) mem_stream_port_i (
    .clk_i, .rst_i,
    .req_i      (m2s_req), .req_valid_i(m2s_req_valid), .req_ready_o(m2s_req_ready),
    .rsp_o      (m2s_rsp), .rsp_valid_o(m2s_rsp_valid), .rsp_ready_i(m2s_rsp_ready),
    .mem_req_o, .mem_valid_o, .mem_gnt_i, .mem_rsp_i, .mem_rvalid_i
  );

  resp_composer resp_composer_i (
    .clk_i, .rst_i,
    .rsp_i        (m2s_rsp), .rsp_valid_i(m2s_rsp_valid), .rsp_ready_o(m2s_rsp_ready),
    .meta_i       (meta_buf), .meta_valid_i(meta_buf_valid), .meta_ready_o(meta_buf_ready),
    .route_i      (route_buf), .route_valid_i(route_buf_valid),
    .route_ready_o(route_buf_ready),
    .b_o          (axi_resp_o.b), .b_valid_o(axi_resp_o.b_valid), .b_ready_i(axi_req_i.b_ready),
    .r_o          (axi_resp_o.r), .r_valid_o(axi_resp_o.r_valid), .r_ready_i(axi_req_i.r_ready)
  );

endmodule

//--- verilog/resp_composer.sv
// Response composer.
// Joins memory responses with beat metadata and drives AXI R and B.
`timescale 1ns/1ps

module resp_composer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  mem_port_pkg::mem_rsp_t   rsp_i,
  input  logic                     rsp_valid_i,
  output logic                     rsp_ready_o,
  input  mem_port_pkg::beat_meta_t meta_i,
  input  logic                     meta_valid_i,
  output logic                     meta_ready_o,
  input  mem_port_pkg::route_t     route_i,
  input  logic                     route_valid_i,
  output logic                     route_ready_o,
  output axi_burst_pkg::b_chan_t   b_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  output axi_burst_pkg::r_chan_t   r_o,
  output logic                     r_valid_o,
  input  logic                     r_ready_i
);

  logic all_valid, out_ready, pop;
  logic err_q, exokay_q, next_err, next_exokay;

  function automatic axi_burst_pkg::resp_t encode_resp(logic err, logic exokay);
    if (err) begin
      return axi_burst_pkg::RespSlverr;
    end
    return exokay ? axi_burst_pkg::RespExokay : axi_burst_pkg::RespOkay;
  endfunction

  assign all_valid = rsp_valid_i & meta_valid_i & route_valid_i;
  // Inner write beats have no AXI output and pop at once.
  assign out_ready = route_i.to_r ? r_ready_i : (route_i.to_b ? b_ready_i : 1'b1);
  assign pop       = all_valid & out_ready;

  assign rsp_ready_o   = pop;
  assign meta_ready_o  = pop;
  assign route_ready_o = pop;

  // Status of the write burst so far, including this beat.
  assign next_err    = err_q | rsp_i.err;
  assign next_exokay = exokay_q & rsp_i.exokay;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q    <= 1'b0;
      exokay_q <= 1'b1;
    end else if (pop && meta_i.write) begin
      err_q    <= meta_i.last ? 1'b0 : next_err;
      exokay_q <= meta_i.last ? 1'b1 : next_exokay;
    end
  end

  assign r_valid_o = all_valid & route_i.to_r;
  assign r_o       = '{id: meta_i.id, data: rsp_i.rdata, last: meta_i.last,
                       resp: encode_resp(rsp_i.err, rsp_i.exokay)};
  assign b_valid_o = all_valid & route_i.to_b;
  assign b_o       = '{id: meta_i.id, resp: encode_resp(next_err, next_exokay)};

  // Held by the buffers upstream while the master stalls.
  assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
  else $error("R changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
  else $error("B changed under back-pressure");

endmodule

//--- verilog/mem_stream_port.sv
// Memory stream port.
// Issues requests with req/gnt and buffers the in-order responses.
`timescale 1ns/1ps

module mem_stream_port #(
  parameter int unsigned BufDepth = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  mem_port_pkg::mem_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output mem_port_pkg::mem_rsp_t rsp_o,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output mem_port_pkg::mem_req_t mem_req_o,
  output logic                   mem_valid_o,
  input  logic                   mem_gnt_i,
  input  mem_port_pkg::mem_rsp_t mem_rsp_i,
  input  logic                   mem_rvalid_i
);

  localparam int unsigned CntWidth = $clog2(BufDepth + 1);

  // Credits cover responses in flight plus those waiting in the buffer.
  logic [CntWidth-1:0] cnt_q;
  logic                has_credit, req_hs, rsp_hs, buf_ready;

  assign has_credit  = (cnt_q < CntWidth'(BufDepth));
  assign mem_req_o   = req_i;
  assign mem_valid_o = req_valid_i & has_credit;
  assign req_ready_o = has_credit & mem_gnt_i;
  assign req_hs      = mem_valid_o & mem_gnt_i;
  assign rsp_hs      = rsp_valid_o & rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (req_hs && !rsp_hs) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (rsp_hs && !req_hs) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  resp_fifo #(
    .Depth    (BufDepth),
    .payload_t(mem_port_pkg::mem_rsp_t)
  ) rsp_buf_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (mem_rsp_i),
    .valid_i(mem_rvalid_i),
    .ready_o(buf_ready),
    .data_o (rsp_o),
    .valid_o(rsp_valid_o),
    .ready_i(rsp_ready_i)
  );

  // Every response belongs to a granted request and finds room in the buffer.
  assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rvalid_i |-> cnt_q != '0 && buf_ready)
  else $error("Memory response without an outstanding request");

endmodule

//--- verilog/rw_arbiter.sv
// Read/write arbiter.
// Picks a read or write beat and forks it to memory, metadata and route.
`timescale 1ns/1ps

module rw_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  mem_port_pkg::beat_meta_t rd_beat_i,
  input  mem_port_pkg::beat_meta_t wr_beat_i,
  input  logic                     rd_valid_i,
  input  logic                     wr_valid_i,
  output logic                     rd_ready_o,
  output logic                     wr_ready_o,
  input  logic                     rd_busy_i,
  input  logic                     wr_busy_i,
  input  axi_burst_pkg::data_t     wdata_i,
  output mem_port_pkg::mem_req_t   mem_req_o,
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output mem_port_pkg::beat_meta_t meta_o,
  output logic                     meta_valid_o,
  input  logic                     meta_ready_i,
  output mem_port_pkg::route_t     route_o,
  output logic                     route_valid_o,
  input  logic                     route_ready_i
);

  // Select is 1 for the write side.
  logic                     sel_q, sel_d, lock_q;
  logic                     arb_valid, arb_ready;
  logic [2:0]               done_q, done_d, branch_ready, branch_valid;
  mem_port_pkg::beat_meta_t beat;

  always_comb begin
    sel_d = sel_q;
    if (!lock_q) begin
      if (wr_valid_i ^ rd_valid_i) begin
        sel_d = wr_valid_i;
      end else if (wr_valid_i && rd_valid_i) begin
        if (wr_beat_i.qos != rd_beat_i.qos) begin
          sel_d = (wr_beat_i.qos > rd_beat_i.qos);
        end else if (wr_beat_i.last && !rd_beat_i.last) begin
          // Single-beat write ahead of a read burst.
          sel_d = 1'b1;
        end else if (wr_busy_i) begin
          sel_d = 1'b1;
        end else if (rd_busy_i) begin
          sel_d = 1'b0;
        end else begin
          sel_d = ~sel_q;
        end
      end
    end
  end

  assign beat      = sel_d ? wr_beat_i : rd_beat_i;
  assign arb_valid = sel_d ? wr_valid_i : rd_valid_i;

  // Three-way fork where each branch remembers that it has taken the beat.
  assign branch_ready = {route_ready_i, meta_ready_i, mem_req_ready_i};
  assign branch_valid = {3{arb_valid}} & ~done_q;
  assign arb_ready    = &(done_q | branch_ready);
  assign rd_ready_o   = ~sel_d & arb_ready;
  assign wr_ready_o   = sel_d & arb_ready;

  always_comb begin
    done_d = done_q | (branch_valid & branch_ready);
    if (arb_valid && arb_ready) begin
      done_d = '0;
    end
  end

  assign mem_req_valid_o = branch_valid[0];
  assign meta_valid_o    = branch_valid[1];
  assign route_valid_o   = branch_valid[2];

  // Read requests carry zero write data.
  assign mem_req_o = '{addr: beat.addr, wdata: beat.write ? wdata_i : '0, strb: beat.strb,
                       we: beat.write, lock: beat.lock};
  assign meta_o    = beat;
  assign route_o   = '{to_b: beat.write & beat.last, to_r: ~beat.write};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
      done_q <= '0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= arb_valid & ~arb_ready;
      done_q <= done_d;
    end
  end

  // A stalled beat stays offered and unchanged until the fork completes.
  assert property (@(posedge clk_i) disable iff (rst_i)
    arb_valid && !arb_ready |=> arb_valid && $stable(beat))
  else $error("Arbiter changed its locked beat");

endmodule

//--- verilog/burst_sequencer.sv
// Burst sequencer.
// Walks accepted AR and AW bursts into per-beat metadata streams.
`timescale 1ns/1ps

module burst_sequencer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  axi_burst_pkg::axi_req_t  axi_req_i,
  output logic                     ar_ready_o,
  output logic                     aw_ready_o,
  output logic                     w_ready_o,
  output mem_port_pkg::beat_meta_t rd_beat_o,
  output logic                     rd_valid_o,
  input  logic                     rd_ready_i,
  output mem_port_pkg::beat_meta_t wr_beat_o,
  output logic                     wr_valid_o,
  input  logic                     wr_ready_i,
  output logic                     rd_busy_o,
  output logic                     wr_busy_o,
  output axi_burst_pkg::data_t     wdata_o
);

  axi_burst_pkg::len_t      r_cnt_q, r_cnt_d, w_cnt_q, w_cnt_d;
  mem_port_pkg::beat_meta_t rd_meta_q, rd_meta_d, wr_meta_q, wr_meta_d;

  assign rd_busy_o = (r_cnt_q != '0);
  assign wr_busy_o = (w_cnt_q != '0);
  assign wdata_o   = axi_req_i.w.data;

  // Read side.
  always_comb begin
    ar_ready_o = 1'b0;
    rd_valid_o = 1'b0;
    rd_beat_o  = rd_meta_q;
    rd_meta_d  = rd_meta_q;
    r_cnt_d    = r_cnt_q;
    if (r_cnt_q != '0) begin
      rd_beat_o.addr = rd_meta_q.addr + axi_burst_pkg::num_bytes(rd_meta_q.size);
      rd_beat_o.last = (r_cnt_q == 8'd1);
      rd_valid_o     = 1'b1;
      if (rd_ready_i) begin
        r_cnt_d   = r_cnt_q - 8'd1;
        rd_meta_d = rd_beat_o;
      end
    end else if (axi_req_i.ar_valid) begin
      // First beat keeps the unaligned address.
      rd_beat_o = '{addr: axi_req_i.ar.addr, id: axi_req_i.ar.id, size: axi_req_i.ar.size,
                    lock: axi_req_i.ar.lock, qos: axi_req_i.ar.qos, write: 1'b0,
                    last: (axi_req_i.ar.len == '0), strb: '0};
      rd_valid_o = 1'b1;
      if (rd_ready_i) begin
        ar_ready_o     = 1'b1;
        r_cnt_d        = axi_req_i.ar.len;
        rd_meta_d      = rd_beat_o;
        rd_meta_d.addr = axi_burst_pkg::aligned_addr(axi_req_i.ar.addr, axi_req_i.ar.size);
      end
    end
  end

  // A write beat waits for its W data.
  always_comb begin
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    wr_valid_o = 1'b0;
    wr_beat_o  = wr_meta_q;
    wr_meta_d  = wr_meta_q;
    w_cnt_d    = w_cnt_q;
    if (w_cnt_q != '0) begin
      wr_beat_o.addr = wr_meta_q.addr + axi_burst_pkg::num_bytes(wr_meta_q.size);
      wr_beat_o.last = (w_cnt_q == 8'd1);
      wr_beat_o.strb = axi_req_i.w.strb;
      wr_valid_o     = axi_req_i.w_valid;
      if (axi_req_i.w_valid && wr_ready_i) begin
        w_ready_o = 1'b1;
        w_cnt_d   = w_cnt_q - 8'd1;
        wr_meta_d = wr_beat_o;
      end
    end else if (axi_req_i.aw_valid && axi_req_i.w_valid) begin
      wr_beat_o = '{addr: axi_req_i.aw.addr, id: axi_req_i.aw.id, size: axi_req_i.aw.size,
                    lock: axi_req_i.aw.lock, qos: axi_req_i.aw.qos, write: 1'b1,
                    last: (axi_req_i.aw.len == '0), strb: axi_req_i.w.strb};
      wr_valid_o = 1'b1;
      if (wr_ready_i) begin
        aw_ready_o     = 1'b1;
        w_ready_o      = 1'b1;
        w_cnt_d        = axi_req_i.aw.len;
        wr_meta_d      = wr_beat_o;
        wr_meta_d.addr = axi_burst_pkg::aligned_addr(axi_req_i.aw.addr, axi_req_i.aw.size);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_cnt_q <= '0;
      w_cnt_q <= '0;
    end else begin
      r_cnt_q <= r_cnt_d;
      w_cnt_q <= w_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_meta_q <= rd_meta_d;
    wr_meta_q <= wr_meta_d;
  end

  // Only INCR is walked, so longer bursts must be INCR.
  assert property (@(posedge clk_i) disable iff (rst_i)
    axi_req_i.ar_valid && axi_req_i.ar.len != '0 |-> axi_req_i.ar.burst == axi_burst_pkg::BurstIncr)
  else $error("AR burst of %0d beats is not INCR", axi_req_i.ar.len + 1);

  assert property (@(posedge clk_i) disable iff (rst_i)
    axi_req_i.aw_valid && axi_req_i.aw.len != '0 |-> axi_req_i.aw.burst == axi_burst_pkg::BurstIncr)
  else $error("AW burst of %0d beats is not INCR", axi_req_i.aw.len + 1);

endmodule

//--- verilog/resp_fifo.sv
// Fall-through FIFO for any payload type.
// An empty FIFO passes its input straight to the output.
`timescale 1ns/1ps

module resp_fifo #(
  parameter int unsigned Depth = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   rd_ptr_q, wr_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  empty, full, push, pop;

  assign empty   = (count_q == '0);
  assign full    = (count_q == CntWidth'(Depth));
  assign ready_o = ~full;
  assign valid_o = ~empty | valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  // A beat that falls through is never stored.
  assign push = valid_i & ~full & ~(empty & ready_i);
  assign pop  = ready_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // An empty or a full FIFO has its pointers level.
  assert property (@(posedge clk_i) disable iff (rst_i) empty |-> rd_ptr_q == wr_ptr_q)
  else $error("FIFO empty with its pointers apart");

  assert property (@(posedge clk_i) disable iff (rst_i) full |-> rd_ptr_q == wr_ptr_q)
  else $error("FIFO full with its pointers apart");

endmodule

//--- verilog/mem_port_pkg.sv
// Memory side definitions.
// Request and response of the memory port, beat metadata and response routing.
package mem_port_pkg;

  // One beat of a burst as it travels from the sequencer to the response path.
  typedef struct packed {
    axi_burst_pkg::addr_t addr;
    axi_burst_pkg::id_t   id;
    axi_burst_pkg::size_t size;
    logic                 lock;
    axi_burst_pkg::qos_t  qos;
    logic                 write;
    logic                 last;
    axi_burst_pkg::strb_t strb;
  } beat_meta_t;

  typedef struct packed {
    axi_burst_pkg::addr_t addr;
    axi_burst_pkg::data_t wdata;
    axi_burst_pkg::strb_t strb;
    logic                 we;
    logic                 lock;
  } mem_req_t;

  typedef struct packed {
    axi_burst_pkg::data_t rdata;
    logic                 err;
    logic                 exokay;
  } mem_rsp_t;

  // Which AXI channel a response goes to.
  typedef struct packed {
    logic to_b;
    logic to_r;
  } route_t;

endpackage

//--- verilog/axi_burst_pkg.sv
// AXI4 slave side definitions.
// Fixed bus widths, burst field types and the channel structs.
package axi_burst_pkg;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;
  // Beat count minus one.
  typedef logic [7:0]           len_t;
  // Log2 of the bytes per beat.
  typedef logic [2:0]           size_t;
  typedef logic [1:0]           burst_t;
  typedef logic [3:0]           qos_t;
  typedef logic [1:0]           resp_t;

  localparam burst_t BurstIncr  = 2'b01;
  localparam resp_t  RespOkay   = 2'b00;
  localparam resp_t  RespExokay = 2'b01;
  localparam resp_t  RespSlverr = 2'b10;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    logic   lock;
    qos_t   qos;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    ax_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ax_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // Bytes moved by one beat of the given size.
  function automatic addr_t num_bytes(size_t size);
    return addr_t'(1) << size;
  endfunction

  // Address rounded down to the beat size.
  function automatic addr_t aligned_addr(addr_t addr, size_t size);
    return addr & ~(num_bytes(size) - addr_t'(1));
  endfunction

endpackage
